// ==== src/framerPkg.sv ====
`default_nettype none

package framerPkg;

    // Control states, 2'b10 is unused
    typedef enum logic [1:0] {
        outOfSync   = 2'b00,
        skipPayload = 2'b01,
        testSync    = 2'b11
    } syncStateT;

    typedef logic [31:0]        busWordT;
    typedef logic [3:0]         regAddrT;
    typedef logic signed [6:0]  corrScoreT;
    typedef logic [4:0]         bitIndexT;
    typedef logic [15:0]        wordIndexT;

    // Register word addresses
    localparam regAddrT addrGeometry  = 4'd0;
    localparam regAddrT addrSyncword  = 4'd1;
    localparam regAddrT addrSyncMask  = 4'd2;
    localparam regAddrT addrThreshold = 4'd3;
    // Read-only
    localparam regAddrT addrStatus    = 4'd4;

endpackage

`default_nettype wire

// ==== src/framerRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module framerRegs (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cs,
    input  wire [3:0]               byteWe,
    input  framerPkg::regAddrT      addr,
    input  framerPkg::busWordT      din,
    input  framerPkg::syncStateT    syncState,
    input  wire                     invertData,
    input  wire [1:0]               rotation,
    input  wire                     framesync,
    output framerPkg::busWordT      dout,
    output framerPkg::busWordT      syncword,
    output framerPkg::busWordT      syncMask,
    output framerPkg::corrScoreT    syncThreshold,
    output framerPkg::bitIndexT     bitsPerWord,
    output framerPkg::wordIndexT    wordsPerFrame,
    output framerPkg::bitIndexT     syncwordBits
);

    framerPkg::busWordT geometryReg;
    framerPkg::busWordT thresholdReg;
    framerPkg::busWordT maskNext;
    framerPkg::busWordT statusWord;
    logic               writeEn;
    logic               readEn;

    // Replace only the bytes that are enabled
    function automatic framerPkg::busWordT mergeBytes(input framerPkg::busWordT oldWord,
                                                      input framerPkg::busWordT newWord,
                                                      input logic [3:0] we);
        framerPkg::busWordT result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Index of the highest set bit, 0 for an empty mask
    function automatic framerPkg::bitIndexT highestBit(input framerPkg::busWordT mask);
        framerPkg::bitIndexT index;
        index = '0;
        for (int i = 0; i < 32; i++) begin
            if (mask[i]) begin
                index = framerPkg::bitIndexT'(i);
            end
        end
        return index;
    endfunction

    assign writeEn  = cs && (byteWe != 4'b0000);
    assign readEn   = cs && (byteWe == 4'b0000);
    assign maskNext = mergeBytes(syncMask, din, byteWe);

    assign statusWord = {19'd0, syncwordBits, 2'b00, rotation, invertData, syncState, framesync};

    always_ff @(posedge clk) begin
        if (reset) begin
            geometryReg  <= '0;
            syncword     <= '0;
            syncMask     <= '0;
            thresholdReg <= '0;
            syncwordBits <= '0;
        end else if (writeEn) begin
            case (addr)
                framerPkg::addrGeometry:  geometryReg <= mergeBytes(geometryReg, din, byteWe);
                framerPkg::addrSyncword:  syncword <= mergeBytes(syncword, din, byteWe);
                framerPkg::addrSyncMask: begin
                    syncMask     <= maskNext;
                    syncwordBits <= highestBit(maskNext);
                end
                framerPkg::addrThreshold: thresholdReg <= mergeBytes(thresholdReg, din, byteWe);
                default: ;
            endcase
        end
    end

    // Read word is held until the next read
    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
        end else if (readEn) begin
            case (addr)
                framerPkg::addrGeometry:  dout <= geometryReg;
                framerPkg::addrSyncword:  dout <= syncword;
                framerPkg::addrSyncMask:  dout <= syncMask;
                framerPkg::addrThreshold: dout <= thresholdReg;
                framerPkg::addrStatus:    dout <= statusWord;
                default:                  dout <= '0;
            endcase
        end
    end

    assign bitsPerWord   = geometryReg[4:0];
    assign wordsPerFrame = geometryReg[31:16];
    assign syncThreshold = thresholdReg[6:0];

endmodule

`default_nettype wire

// ==== src/syncCorrelator.sv ====
`timescale 1ns/1ps
`default_nettype none

module syncCorrelator (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     bitEn,
    input  wire                     bitIn,
    input  wire                     invertData,
    input  framerPkg::busWordT      syncword,
    input  framerPkg::busWordT      syncMask,
    input  framerPkg::corrScoreT    syncThreshold,
    output logic                    syncDetected,
    output logic                    negPolarity,
    output logic                    framedBitOut
);

    logic                   polarityBit;
    framerPkg::busWordT     corrShift;
    framerPkg::corrScoreT   bitSum;
    framerPkg::corrScoreT   negThreshold;

    // Masked bits count +1 on agreement and -1 otherwise
    function automatic logic signed [3:0] nibbleScore(input logic [3:0] data,
                                                      input logic [3:0] pattern,
                                                      input logic [3:0] mask);
        logic signed [3:0] score;
        score = 4'sd0;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                if (data[i] == pattern[i]) begin
                    score = score + 4'sd1;
                end else begin
                    score = score - 4'sd1;
                end
            end
        end
        return score;
    endfunction

    // Polarity correction, one strobe ahead of the window
    always_ff @(posedge clk) begin
        if (bitEn) begin
            polarityBit <= bitIn ^ invertData;
        end
    end

    // Newest bit enters at bit 0
    always_ff @(posedge clk) begin
        if (bitEn) begin
            corrShift <= {corrShift[30:0], polarityBit};
        end
    end

    // Sum of the eight nibble scores
    always_comb begin
        logic signed [3:0] nibble;
        bitSum = '0;
        for (int n = 0; n < 8; n++) begin
            nibble = nibbleScore(corrShift[4*n +: 4], syncword[4*n +: 4], syncMask[4*n +: 4]);
            bitSum = bitSum + framerPkg::corrScoreT'(nibble);
        end
    end

    assign negThreshold = -syncThreshold;

    // Detection flags, polarity kept from the last hit
    always_ff @(posedge clk) begin
        if (reset) begin
            syncDetected <= 1'b0;
            negPolarity  <= 1'b0;
        end else if (bitEn) begin
            if (bitSum > syncThreshold) begin
                syncDetected <= 1'b1;
                negPolarity  <= 1'b0;
            end else if (bitSum < negThreshold) begin
                syncDetected <= 1'b1;
                negPolarity  <= 1'b1;
            end else begin
                syncDetected <= 1'b0;
            end
        end
    end

    assign framedBitOut = corrShift[1];

endmodule

`default_nettype wire

// ==== src/frameSyncFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameSyncFsm #(
    parameter int maxSyncCount = 5
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     bitEn,
    input  wire                     syncDetected,
    input  wire                     negPolarity,
    input  framerPkg::bitIndexT     bitsPerWord,
    input  framerPkg::wordIndexT    wordsPerFrame,
    input  framerPkg::bitIndexT     syncwordBits,
    output framerPkg::syncStateT    syncState,
    output logic                    invertData,
    output logic [1:0]              rotation,
    output logic                    framesync,
    output logic                    framesyncPulse
);

    // Wide enough to hold maxSyncCount, never zero bits
    localparam int countWidth = $clog2(maxSyncCount + 2);

    framerPkg::bitIndexT    bitCount;
    framerPkg::wordIndexT   wordCount;
    logic [countWidth-1:0]  syncCount;
    logic                   endOfPayload;

    assign endOfPayload = (bitCount == '0) && (wordCount == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            syncState  <= framerPkg::outOfSync;
            invertData <= 1'b0;
            rotation   <= 2'd0;
            framesync  <= 1'b0;
            bitCount   <= '0;
            wordCount  <= '0;
            syncCount  <= '0;
        end else if (bitEn) begin
            case (syncState)
                framerPkg::outOfSync: begin
                    if (syncDetected) begin
                        bitCount   <= bitsPerWord;
                        wordCount  <= wordsPerFrame;
                        syncCount  <= '0;
                        invertData <= negPolarity;
                        syncState  <= framerPkg::skipPayload;
                    end else if (endOfPayload) begin
                        // Window expired, move the search along
                        bitCount  <= syncwordBits;
                        wordCount <= wordsPerFrame;
                        rotation  <= rotation + 2'd1;
                    end else if (bitCount == '0) begin
                        bitCount  <= bitsPerWord;
                        wordCount <= wordCount - 1'b1;
                    end else begin
                        bitCount <= bitCount - 1'b1;
                    end
                end

                framerPkg::skipPayload: begin
                    if (endOfPayload) begin
                        bitCount  <= syncwordBits;
                        syncState <= framerPkg::testSync;
                    end else if (bitCount == '0) begin
                        bitCount  <= bitsPerWord;
                        wordCount <= wordCount - 1'b1;
                    end else begin
                        bitCount <= bitCount - 1'b1;
                    end
                end

                framerPkg::testSync: begin
                    if (bitCount != '0) begin
                        bitCount <= bitCount - 1'b1;
                    end else if (syncDetected && !negPolarity) begin
                        // Good re-test, sync declared at the cap
                        if (syncCount < maxSyncCount) begin
                            syncCount <= syncCount + 1'b1;
                        end else begin
                            framesync <= 1'b1;
                        end
                        bitCount  <= bitsPerWord;
                        wordCount <= wordsPerFrame;
                        syncState <= framerPkg::skipPayload;
                    end else if (syncCount == '0) begin
                        // Lost, restart the search in the next rotation
                        bitCount   <= syncwordBits;
                        wordCount  <= wordsPerFrame;
                        rotation   <= rotation + 2'd1;
                        invertData <= 1'b0;
                        framesync  <= 1'b0;
                        syncState  <= framerPkg::outOfSync;
                    end else begin
                        syncCount <= syncCount - 1'b1;
                        bitCount  <= bitsPerWord;
                        wordCount <= wordsPerFrame;
                        syncState <= framerPkg::skipPayload;
                    end
                end

                default: begin
                    syncState  <= framerPkg::outOfSync;
                    invertData <= 1'b0;
                    framesync  <= 1'b0;
                    bitCount   <= '0;
                    wordCount  <= '0;
                    syncCount  <= '0;
                end
            endcase
        end
    end

    assign framesyncPulse = syncDetected & framesync;

endmodule

`default_nettype wire

// ==== src/framerTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module framerTop #(
    parameter int maxSyncCount = 5
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cs,
    input  wire [3:0]               byteWe,
    input  framerPkg::regAddrT      addr,
    input  framerPkg::busWordT      din,
    input  wire                     bitEn,
    input  wire                     bitIn,
    output framerPkg::busWordT      dout,
    output logic                    framedBitOut,
    output logic [1:0]              rotation,
    output logic                    framesync,
    output logic                    framesyncPulse
);

    framerPkg::busWordT     syncword;
    framerPkg::busWordT     syncMask;
    framerPkg::corrScoreT   syncThreshold;
    framerPkg::bitIndexT    bitsPerWord;
    framerPkg::wordIndexT   wordsPerFrame;
    framerPkg::bitIndexT    syncwordBits;
    framerPkg::syncStateT   syncState;
    logic                   invertData;
    logic                   syncDetected;
    logic                   negPolarity;

    framerRegs u_framerRegs (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .byteWe(byteWe),
        .addr(addr),
        .din(din),
        .syncState(syncState),
        .invertData(invertData),
        .rotation(rotation),
        .framesync(framesync),
        .dout(dout),
        .syncword(syncword),
        .syncMask(syncMask),
        .syncThreshold(syncThreshold),
        .bitsPerWord(bitsPerWord),
        .wordsPerFrame(wordsPerFrame),
        .syncwordBits(syncwordBits)
    );

    syncCorrelator u_syncCorrelator (
        .clk(clk),
        .reset(reset),
        .bitEn(bitEn),
        .bitIn(bitIn),
        .invertData(invertData),
        .syncword(syncword),
        .syncMask(syncMask),
        .syncThreshold(syncThreshold),
        .syncDetected(syncDetected),
        .negPolarity(negPolarity),
        .framedBitOut(framedBitOut)
    );

    frameSyncFsm #(
        .maxSyncCount(maxSyncCount)
    ) u_frameSyncFsm (
        .clk(clk),
        .reset(reset),
        .bitEn(bitEn),
        .syncDetected(syncDetected),
        .negPolarity(negPolarity),
        .bitsPerWord(bitsPerWord),
        .wordsPerFrame(wordsPerFrame),
        .syncwordBits(syncwordBits),
        .syncState(syncState),
        .invertData(invertData),
        .rotation(rotation),
        .framesync(framesync),
        .framesyncPulse(framesyncPulse)
    );

endmodule

`default_nettype wire

// ==== tests/framerTb_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module framerTbAssert (
    input wire                      clk,
    input wire                      reset,
    input framerPkg::syncStateT     syncState,
    input wire                      invertData,
    input wire                      framesync
);

    int failCount = 0;

    // Sync is only declared by a good re-test
    framesyncRise: assert property (@(posedge clk) disable iff (reset)
        $rose(framesync) |-> $past(syncState) == framerPkg::testSync)
    else begin
        failCount++;
        $error("framesync rose outside testSync");
    end

    framesyncFall: assert property (@(posedge clk) disable iff (reset)
        $fell(framesync) |-> syncState == framerPkg::outOfSync)
    else begin
        failCount++;
        $error("framesync fell without a return to outOfSync");
    end

    stateEncoding: assert property (@(posedge clk) disable iff (reset)
        syncState inside {framerPkg::outOfSync, framerPkg::skipPayload, framerPkg::testSync})
    else begin
        failCount++;
        $error("control state took an unused encoding");
    end

    // Polarity latches on the first hit and clears on loss
    invertChange: assert property (@(posedge clk) disable iff (reset)
        $changed(invertData) |->
            ($past(syncState) == framerPkg::outOfSync && syncState == framerPkg::skipPayload)
            || ($past(syncState) == framerPkg::testSync && syncState == framerPkg::outOfSync))
    else begin
        failCount++;
        $error("invertData changed outside a sync transition");
    end

endmodule

`default_nettype wire

// ==== tests/framerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module framerTb;

    localparam int maxSyncCount = 5;
    localparam int bitsPerWordCfg = 7;
    localparam int wordsPerFrameCfg = 5;
    localparam int payloadBits = (bitsPerWordCfg + 1) * (wordsPerFrameCfg + 1);
    localparam int frameBits = 32 + payloadBits;
    localparam int totalFrames = 40;
    localparam int watchdogCycles = totalFrames * frameBits * 3 + 2000;

    logic                   clk;
    logic                   reset;
    logic                   cs;
    logic [3:0]             byteWe;
    framerPkg::regAddrT     addr;
    framerPkg::busWordT     din;
    logic                   bitEn;
    logic                   bitIn;
    framerPkg::busWordT     dout;
    logic                   framedBitOut;
    logic [1:0]             rotation;
    logic                   framesync;
    logic                   framesyncPulse;

    framerPkg::busWordT     regModel [0:3];
    framerPkg::busWordT     modelSync;
    framerPkg::busWordT     modelMask;
    int                     modelThr;
    // Corrected and uninverted bit histories with the newest at bit 0
    logic [63:0]            corrHist;
    logic [63:0]            plainHist;
    int                     histCount;
    int                     errorCount;
    int                     checkCount;
    bit                     noisePhase;
    bit                     invPhase;
    bit                     lossPhase;
    bit                     lossSeen;
    bit                     prevSync;
    logic [1:0]             lockedRot;

    framerTop #(.maxSyncCount(maxSyncCount)) u_framerTop (
        .clk(clk), .reset(reset), .cs(cs), .byteWe(byteWe), .addr(addr), .din(din),
        .bitEn(bitEn), .bitIn(bitIn), .dout(dout), .framedBitOut(framedBitOut),
        .rotation(rotation), .framesync(framesync), .framesyncPulse(framesyncPulse)
    );

    bind frameSyncFsm framerTbAssert u_framerTbAssert (
        .clk(clk), .reset(reset), .syncState(syncState),
        .invertData(invertData), .framesync(framesync)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int popCount(input logic [31:0] v);
        int n;
        n = 0;
        foreach (v[i]) n += v[i];
        return n;
    endfunction

    function automatic int highestSetBit(input logic [31:0] v);
        for (int i = 31; i >= 0; i--) begin
            if (v[i]) return i;
        end
        return 0;
    endfunction

    // Masked agreements minus masked disagreements
    function automatic int modelScore(input logic [31:0] window);
        return 2 * popCount(~(window ^ modelSync) & modelMask) - popCount(modelMask);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond === 1'b1) else begin
            errorCount++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic monitorOutputs();
        int score;
        if (histCount >= 3) checkValue("framedBitOut", framedBitOut, corrHist[2]);
        if (histCount >= 34 && framesync) begin
            score = modelScore(corrHist[33:2]);
            checkValue("framesyncPulse", framesyncPulse, score > modelThr || score < -modelThr);
        end
        if (invPhase && framesync) checkValue("framedBitOut", framedBitOut, plainHist[2]);
        if (noisePhase) checkTrue(!framesync, "framesync rose on random data");
        if (lossPhase && dout[2:1] == framerPkg::outOfSync && !dout[0]) lossSeen = 1'b1;
        // Rotation holds through lock and steps once on loss
        if (framesync && !prevSync) lockedRot = rotation;
        if (lossPhase && prevSync && !framesync) begin
            checkValue("rotation", rotation, 2'(lockedRot + 2'd1));
        end
        prevSync = framesync;
    endtask

    // Drive, wait for the edge, check, then return 5 ns after the edge
    task automatic stepCycle(input logic en, input logic rawBit, input logic plainBit);
        bitEn = en;
        bitIn = rawBit;
        @(posedge clk);
        #1;
        if (en) begin
            // dout shows the polarity used at this strobe
            corrHist = {corrHist[62:0], rawBit ^ dout[3]};
            plainHist = {plainHist[62:0], plainBit};
            histCount++;
        end
        monitorOutputs();
        #4;
    endtask

    task automatic busWrite(input framerPkg::regAddrT a, input framerPkg::busWordT d,
                            input logic [3:0] we);
        cs = 1'b1;
        byteWe = we;
        addr = a;
        din = d;
        stepCycle(1'b0, 1'b0, 1'b0);
        cs = 1'b0;
        byteWe = 4'b0000;
    endtask

    task automatic busRead(input framerPkg::regAddrT a, output framerPkg::busWordT d);
        cs = 1'b1;
        byteWe = 4'b0000;
        addr = a;
        stepCycle(1'b0, 1'b0, 1'b0);
        d = dout;
        cs = 1'b0;
    endtask

    task automatic setStatusRead();
        cs = 1'b1;
        byteWe = 4'b0000;
        addr = framerPkg::addrStatus;
        stepCycle(1'b0, 1'b0, 1'b0);
    endtask

    task automatic applyReset(input int cycles);
        reset = 1'b1;
        repeat (cycles) stepCycle(1'b0, 1'b0, 1'b0);
        reset = 1'b0;
    endtask

    task automatic registerTest(input int count);
        framerPkg::regAddrT a;
        framerPkg::busWordT d;
        framerPkg::busWordT readBack;
        logic [3:0] we;
        for (int n = 0; n < count; n++) begin
            a = framerPkg::regAddrT'($urandom % 4);
            d = $urandom;
            we = 4'($urandom % 15 + 1);
            busWrite(a, d, we);
            for (int i = 0; i < 4; i++) begin
                if (we[i]) regModel[a][8*i +: 8] = d[8*i +: 8];
            end
            busRead(a, readBack);
            checkValue($sformatf("dout(reg %0d)", a), readBack, regModel[a]);
            if (a == framerPkg::addrSyncMask) begin
                busRead(framerPkg::addrStatus, readBack);
                checkValue("syncwordBits", readBack[12:8], highestSetBit(regModel[2]));
            end
        end
    endtask

    task automatic configure(input framerPkg::busWordT mask, input int thr);
        busWrite(framerPkg::addrGeometry,
                 {16'(wordsPerFrameCfg), 11'd0, 5'(bitsPerWordCfg)}, 4'hF);
        busWrite(framerPkg::addrSyncword, modelSync, 4'hF);
        busWrite(framerPkg::addrSyncMask, mask, 4'hF);
        busWrite(framerPkg::addrThreshold, 32'(thr), 4'hF);
        modelMask = mask;
        modelThr = thr;
        setStatusRead();
    endtask

    // Holds the bit until a strobe takes it
    task automatic sendBit(input logic rawBit, input logic plainBit);
        logic en;
        en = 1'b0;
        while (!en) begin
            en = ($urandom % 3) != 0;
            stepCycle(en, rawBit, plainBit);
        end
    endtask

    // Sync word first, highest bit leading, then the payload
    task automatic sendFrame(input bit withSync, input bit invert);
        int syncLen;
        logic b;
        syncLen = highestSetBit(modelMask) + 1;
        for (int i = syncLen - 1; i >= 0; i--) begin
            b = withSync ? modelSync[i] : 1'($urandom);
            sendBit(b ^ invert, b);
        end
        for (int i = 0; i < payloadBits; i++) begin
            b = 1'($urandom);
            sendBit(b ^ invert, b);
        end
    endtask

    initial begin
        int seedValue;
        seedValue = $urandom(34512);
        reset = 1'b1;
        cs = 1'b0;
        byteWe = 4'b0000;
        addr = '0;
        din = '0;
        bitEn = 1'b0;
        bitIn = 1'b0;
        corrHist = '0;
        plainHist = '0;
        histCount = 0;
        errorCount = 0;
        checkCount = 0;
        {noisePhase, invPhase, lossPhase, lossSeen} = 4'b0000;
        prevSync = 1'b0;
        lockedRot = '0;
        foreach (regModel[i]) regModel[i] = '0;
        modelSync = $urandom;
        modelMask = '0;
        modelThr = 0;
        #5;
        repeat (8) stepCycle(1'b0, 1'b0, 1'b0);
        reset = 1'b0;
        registerTest(40);

        // Fill the correlator window while the mask is empty
        applyReset(2);
        modelMask = '0;
        modelThr = 0;
        setStatusRead();
        sendFrame(1'b0, 1'b0);

        configure(32'hFFFF_F0FF, 20);
        repeat (8) sendFrame(1'b1, 1'b0);
        checkTrue(framesync, "framesync did not rise within 8 frames");
        repeat (4) sendFrame(1'b1, 1'b0);
        checkTrue(framesync, "framesync dropped while sync words were present");

        lossPhase = 1'b1;
        repeat (maxSyncCount + 2) sendFrame(1'b0, 1'b0);
        lossPhase = 1'b0;
        checkTrue(!framesync, "framesync still high after sync words stopped");
        checkTrue(lossSeen, "state did not return to outOfSync after loss");

        applyReset(2);
        configure(32'hFFFF_F0FF, 20);
        invPhase = 1'b1;
        repeat (8) sendFrame(1'b1, 1'b1);
        checkTrue(framesync, "inverted stream did not lock within 8 frames");
        checkTrue(dout[3], "status invertData not set on the inverted stream");
        repeat (2) sendFrame(1'b1, 1'b1);
        invPhase = 1'b0;

        applyReset(2);
        configure(32'hFFFF_FFFF, 28);
        noisePhase = 1'b1;
        repeat (10) sendFrame(1'b0, 1'b0);
        noisePhase = 1'b0;

        errorCount += u_framerTop.u_frameSyncFsm.u_framerTbAssert.failCount;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", watchdogCycles);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/framerPkg.sv
src/framerRegs.sv
src/syncCorrelator.sv
src/frameSyncFsm.sv
src/framerTop.sv
tests/framerTb_assert.sv
tests/framerTb.sv
